// File: memreq_pkg.sv
package memreq_pkg;

  localparam int ADDR_WIDTH = 24;  // Word address
  localparam int DATA_WIDTH = 32;
  localparam int TID_WIDTH  = 4;
  localparam int MAX_BEATS  = 16;  // Burst buffer depth
  localparam int BEAT_BITS  = 4;

  // First byte of a host frame
  typedef enum logic [7:0] {
    CMD_STORE = 8'h01,
    CMD_FETCH = 8'h80
  } cmd_e;

  // First byte of a reply frame
  typedef enum logic [7:0] {
    REPLY_WDONE = 8'h02,
    REPLY_WFAIL = 8'h03,
    REPLY_RDATA = 8'h81,
    REPLY_RFAIL = 8'h82
  } reply_e;

  typedef struct packed {
    logic [TID_WIDTH-1:0]  tid;
    logic [ADDR_WIDTH-1:0] addr;   // First word of the burst
    logic [BEAT_BITS-1:0]  beats;  // Beats minus one
  } mem_cmd_t;

  typedef enum logic [3:0] {
    P_IDLE, P_LEN, P_ADR0, P_ADR1, P_ADR2, P_TID, P_ISSUE, P_PAYLOAD, P_DISCARD
  } parse_state_e;

  typedef enum logic [1:0] {S_FILL, S_WRITE, S_WAIT, S_REPLY} store_state_e;
  typedef enum logic [1:0] {F_IDLE, F_READ, F_WAIT, F_REPLY} fetch_state_e;
  typedef enum logic [1:0] {GNT_NONE, GNT_STORE, GNT_FETCH} grant_e;

endpackage

// File: byte_stream_if.sv
`timescale 1ns/10ps
interface byte_stream_if;

  logic       valid;
  logic       ready;
  logic [7:0] data;
  logic       last;   // Final byte of a frame

  modport source (
    output valid, data, last,
    input  ready
  );

  modport sink (
    input  valid, data, last,
    output ready
  );

endinterface

// File: mem_port_if.sv
`timescale 1ns/10ps
interface mem_port_if;
  import memreq_pkg::*;

  logic                  req;
  logic                  ready;
  logic                  we;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  rvalid;  // One pulse per accepted request
  logic [DATA_WIDTH-1:0] rdata;
  logic                  err;

  modport requester (
    output req, we, addr, wdata,
    input  ready, rvalid, rdata, err
  );

  modport responder (
    input  req, we, addr, wdata,
    output ready, rvalid, rdata, err
  );

endinterface

// File: cmd_parser.sv
`timescale 1ns/10ps
module cmd_parser (
  input  logic                 bus_clock,
  input  logic                 bus_reset,
  byte_stream_if.sink          host,
  output memreq_pkg::mem_cmd_t store_cmd_o,
  output logic                 store_cmd_valid_o,
  input  logic                 store_cmd_ready_i,
  output memreq_pkg::mem_cmd_t fetch_cmd_o,
  output logic                 fetch_cmd_valid_o,
  input  logic                 fetch_cmd_ready_i,
  byte_stream_if.source        payload
);
  import memreq_pkg::*;

  parse_state_e         state_q;
  cmd_e                 op_q;
  mem_cmd_t             cmd_q;
  logic                 end_q;  // Host frame closed on the tid byte
  logic [BEAT_BITS+1:0] cnt_q;  // Payload bytes left, minus one
  logic                 take_w;
  logic                 issue_w;

  assign take_w = host.valid && host.ready;

  assign store_cmd_o       = cmd_q;
  assign fetch_cmd_o       = cmd_q;
  assign store_cmd_valid_o = state_q == P_ISSUE && op_q == CMD_STORE;
  assign fetch_cmd_valid_o = state_q == P_ISSUE && op_q == CMD_FETCH;
  assign issue_w = (store_cmd_valid_o && store_cmd_ready_i) ||
                   (fetch_cmd_valid_o && fetch_cmd_ready_i);

  // Payload is steered straight through
  assign payload.valid = state_q == P_PAYLOAD && host.valid;
  assign payload.data  = host.data;
  assign payload.last  = host.last || cnt_q == '0;

  always_comb begin
    case (state_q)
      P_ISSUE:   host.ready = 1'b0;  // Wait for the engine
      P_PAYLOAD: host.ready = payload.ready;
      default:   host.ready = 1'b1;
    endcase
  end

  // Header fields
  always_ff @(posedge bus_clock) begin
    if (take_w) begin
      case (state_q)
        P_IDLE:    op_q <= cmd_e'(host.data);
        P_LEN:     cmd_q.beats <= host.data[BEAT_BITS-1:0];
        P_ADR0:    cmd_q.addr[7:0] <= host.data;
        P_ADR1:    cmd_q.addr[15:8] <= host.data;
        P_ADR2:    cmd_q.addr[23:16] <= host.data;
        P_TID: begin
          cmd_q.tid <= host.data[7:8-TID_WIDTH];
          end_q     <= host.last;
          cnt_q     <= {cmd_q.beats, 2'b11};
        end
        P_PAYLOAD: cnt_q <= cnt_q - 1'b1;
        default:   ;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= P_IDLE;
    end else begin
      case (state_q)
        P_IDLE: begin
          if (take_w && !host.last) begin
            if (host.data == CMD_STORE || host.data == CMD_FETCH) begin
              state_q <= P_LEN;
            end else begin
              state_q <= P_DISCARD;  // Unknown command
            end
          end
        end
        // A short header ends the frame early and is dropped
        P_LEN:  if (take_w) state_q <= host.last ? P_IDLE : P_ADR0;
        P_ADR0: if (take_w) state_q <= host.last ? P_IDLE : P_ADR1;
        P_ADR1: if (take_w) state_q <= host.last ? P_IDLE : P_ADR2;
        P_ADR2: if (take_w) state_q <= host.last ? P_IDLE : P_TID;
        P_TID:  if (take_w) state_q <= P_ISSUE;
        P_ISSUE: begin
          if (issue_w) begin
            if (op_q == CMD_STORE) begin
              state_q <= P_PAYLOAD;
            end else begin
              state_q <= end_q ? P_IDLE : P_DISCARD;
            end
          end
        end
        P_PAYLOAD: begin
          if (take_w && payload.last) begin
            state_q <= host.last ? P_IDLE : P_DISCARD;  // Surplus bytes dropped
          end
        end
        P_DISCARD: if (take_w && host.last) state_q <= P_IDLE;
        default:   state_q <= P_IDLE;
      endcase
    end
  end

endmodule

// File: store_engine.sv
`timescale 1ns/10ps
module store_engine (
  input  logic                 bus_clock,
  input  logic                 bus_reset,
  input  memreq_pkg::mem_cmd_t cmd_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  byte_stream_if.sink          payload,
  mem_port_if.requester        mem,
  byte_stream_if.source        reply
);
  import memreq_pkg::*;

  store_state_e          state_q;
  mem_cmd_t              cmd_q;
  logic                  loaded_q;   // Command held while the buffer fills
  logic [BEAT_BITS+1:0]  fill_q;     // Byte position within the burst
  logic [BEAT_BITS-1:0]  wr_idx_q;
  logic [BEAT_BITS:0]    rsp_cnt_q;
  logic                  err_q;
  logic                  tid_sel_q;  // Second reply byte
  logic [DATA_WIDTH-1:0] wbuf_q [MAX_BEATS];

  assign cmd_ready_o   = state_q == S_FILL && !loaded_q;
  assign payload.ready = state_q == S_FILL && loaded_q;

  assign mem.req   = state_q == S_WRITE;
  assign mem.we    = 1'b1;
  assign mem.addr  = cmd_q.addr + ADDR_WIDTH'(wr_idx_q);
  assign mem.wdata = wbuf_q[wr_idx_q];

  // Status byte, then tid
  assign reply.valid = state_q == S_REPLY;
  assign reply.last  = tid_sel_q;
  assign reply.data  = tid_sel_q ? 8'(cmd_q.tid) : (err_q ? REPLY_WFAIL : REPLY_WDONE);

  always_ff @(posedge bus_clock) begin
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
    if (payload.valid && payload.ready) begin  // Little-endian packing
      wbuf_q[fill_q[BEAT_BITS+1:2]][8*fill_q[1:0] +: 8] <= payload.data;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q   <= S_FILL;
      loaded_q  <= 1'b0;
      fill_q    <= '0;
      wr_idx_q  <= '0;
      rsp_cnt_q <= '0;
      err_q     <= 1'b0;
      tid_sel_q <= 1'b0;
    end else begin
      if (mem.rvalid) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
        err_q     <= err_q | mem.err;
      end
      case (state_q)
        S_FILL: begin
          if (cmd_valid_i && cmd_ready_o) begin
            loaded_q <= 1'b1;
            fill_q   <= '0;
          end else if (payload.valid && payload.ready) begin
            fill_q <= fill_q + 1'b1;
            if (payload.last) begin
              state_q   <= S_WRITE;
              wr_idx_q  <= '0;
              rsp_cnt_q <= '0;
              err_q     <= 1'b0;
            end
          end
        end
        S_WRITE: begin
          if (mem.ready) begin
            wr_idx_q <= wr_idx_q + 1'b1;
            if (wr_idx_q == cmd_q.beats) state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp_cnt_q == {1'b0, cmd_q.beats} + 1'b1) begin  // All writes answered
            state_q   <= S_REPLY;
            tid_sel_q <= 1'b0;
          end
        end
        S_REPLY: begin
          if (reply.ready) begin
            tid_sel_q <= !tid_sel_q;
            if (tid_sel_q) begin
              state_q  <= S_FILL;
              loaded_q <= 1'b0;
            end
          end
        end
        default: state_q <= S_FILL;
      endcase
    end
  end

endmodule

// File: fetch_engine.sv
`timescale 1ns/10ps
module fetch_engine (
  input  logic                 bus_clock,
  input  logic                 bus_reset,
  input  memreq_pkg::mem_cmd_t cmd_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  mem_port_if.requester        mem,
  byte_stream_if.source        reply
);
  import memreq_pkg::*;

  fetch_state_e          state_q;
  mem_cmd_t              cmd_q;
  logic [BEAT_BITS-1:0]  rd_idx_q;
  logic [BEAT_BITS:0]    rsp_cnt_q;  // Also the buffer write pointer
  logic                  err_q;
  logic [BEAT_BITS+2:0]  out_q;      // Reply byte position
  logic [BEAT_BITS+2:0]  dsel_w;     // Data byte position
  logic [DATA_WIDTH-1:0] word_w;
  logic [DATA_WIDTH-1:0] rbuf_q [MAX_BEATS];

  assign cmd_ready_o = state_q == F_IDLE;

  assign mem.req   = state_q == F_READ;
  assign mem.we    = 1'b0;
  assign mem.addr  = cmd_q.addr + ADDR_WIDTH'(rd_idx_q);
  assign mem.wdata = '0;

  assign dsel_w      = out_q - 2'd2;  // Skip status and tid
  assign word_w      = rbuf_q[dsel_w[BEAT_BITS+1:2]];
  assign reply.valid = state_q == F_REPLY;
  assign reply.last  = out_q == {cmd_q.beats, 2'b01} + 3'd4;  // Byte 4*beats+5

  always_comb begin
    case (out_q)
      '0:      reply.data = err_q ? REPLY_RFAIL : REPLY_RDATA;
      'd1:     reply.data = 8'(cmd_q.tid);
      default: reply.data = word_w[8*dsel_w[1:0] +: 8];
    endcase
  end

  always_ff @(posedge bus_clock) begin
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
    if (mem.rvalid) begin
      rbuf_q[rsp_cnt_q[BEAT_BITS-1:0]] <= mem.rdata;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q   <= F_IDLE;
      rd_idx_q  <= '0;
      rsp_cnt_q <= '0;
      err_q     <= 1'b0;
      out_q     <= '0;
    end else begin
      if (mem.rvalid) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
        err_q     <= err_q | mem.err;
      end
      case (state_q)
        F_IDLE: begin
          if (cmd_valid_i) begin
            state_q   <= F_READ;
            rd_idx_q  <= '0;
            rsp_cnt_q <= '0;
            err_q     <= 1'b0;
          end
        end
        F_READ: begin  // Back to back reads
          if (mem.ready) begin
            rd_idx_q <= rd_idx_q + 1'b1;
            if (rd_idx_q == cmd_q.beats) state_q <= F_WAIT;
          end
        end
        F_WAIT: begin
          if (rsp_cnt_q == {1'b0, cmd_q.beats} + 1'b1) begin
            state_q <= F_REPLY;
            out_q   <= '0;
          end
        end
        F_REPLY: begin
          if (reply.ready) begin
            out_q <= out_q + 1'b1;
            if (reply.last) state_q <= F_IDLE;
          end
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/10ps
module mem_arbiter (
  input  logic          bus_clock,
  input  logic          bus_reset,
  mem_port_if.responder store_port,
  mem_port_if.responder fetch_port,
  mem_port_if.requester mem
);
  import memreq_pkg::*;

  grant_e             owner_q;
  grant_e             last_q;   // Winner of the previous burst
  grant_e             grant_w;
  logic               acc_w;
  logic [BEAT_BITS:0] pend_q;   // Responses still owed to the owner
  logic [BEAT_BITS:0] pend_w;

  // Pick an engine when idle, so the first request costs no cycle
  always_comb begin
    grant_w = owner_q;
    if (owner_q == GNT_NONE) begin
      if (store_port.req && fetch_port.req) begin
        grant_w = last_q == GNT_STORE ? GNT_FETCH : GNT_STORE;
      end else if (store_port.req) begin
        grant_w = GNT_STORE;
      end else if (fetch_port.req) begin
        grant_w = GNT_FETCH;
      end
    end
  end

  always_comb begin
    if (grant_w == GNT_FETCH) begin
      mem.req   = fetch_port.req;
      mem.we    = fetch_port.we;
      mem.addr  = fetch_port.addr;
      mem.wdata = fetch_port.wdata;
    end else begin
      mem.req   = grant_w == GNT_STORE && store_port.req;
      mem.we    = store_port.we;
      mem.addr  = store_port.addr;
      mem.wdata = store_port.wdata;
    end
  end

  assign store_port.ready  = grant_w == GNT_STORE && mem.ready;
  assign fetch_port.ready  = grant_w == GNT_FETCH && mem.ready;
  assign store_port.rvalid = owner_q == GNT_STORE && mem.rvalid;
  assign fetch_port.rvalid = owner_q == GNT_FETCH && mem.rvalid;
  assign store_port.rdata  = mem.rdata;
  assign fetch_port.rdata  = mem.rdata;
  assign store_port.err    = mem.err;
  assign fetch_port.err    = mem.err;

  assign acc_w  = mem.req && mem.ready;
  assign pend_w = pend_q + {{BEAT_BITS{1'b0}}, acc_w} - {{BEAT_BITS{1'b0}}, mem.rvalid};

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      owner_q <= GNT_NONE;
      last_q  <= GNT_NONE;
      pend_q  <= '0;
    end else begin
      pend_q <= pend_w;
      if (owner_q == GNT_NONE && acc_w) begin
        owner_q <= grant_w;
        last_q  <= grant_w;
      end else if (owner_q != GNT_NONE && !mem.req && pend_w == '0) begin
        owner_q <= GNT_NONE;  // Burst drained
      end
    end
  end

endmodule

// File: reply_mux.sv
`timescale 1ns/10ps
module reply_mux (
  input  logic          bus_clock,
  input  logic          bus_reset,
  byte_stream_if.sink   store_reply,
  byte_stream_if.sink   fetch_reply,
  byte_stream_if.source host
);
  import memreq_pkg::*;

  grant_e own_q;   // Held for the rest of a frame
  grant_e pick_w;

  always_comb begin
    pick_w = own_q;
    if (own_q == GNT_NONE) begin
      if (store_reply.valid) begin
        pick_w = GNT_STORE;  // Store side wins ties
      end else if (fetch_reply.valid) begin
        pick_w = GNT_FETCH;
      end
    end
  end

  always_comb begin
    if (pick_w == GNT_FETCH) begin
      host.valid = fetch_reply.valid;
      host.data  = fetch_reply.data;
      host.last  = fetch_reply.last;
    end else begin
      host.valid = store_reply.valid;
      host.data  = store_reply.data;
      host.last  = store_reply.last;
    end
  end

  assign store_reply.ready = pick_w == GNT_STORE && host.ready;
  assign fetch_reply.ready = pick_w == GNT_FETCH && host.ready;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      own_q <= GNT_NONE;
    end else if (host.valid && host.ready) begin
      own_q <= host.last ? GNT_NONE : pick_w;
    end
  end

endmodule

// File: memreq_top.sv
`timescale 1ns/10ps
module memreq_top (
  input  logic                              bus_clock,
  input  logic                              bus_reset,
  input  logic                              s_valid_i,
  output logic                              s_ready_o,
  input  logic [7:0]                        s_data_i,
  input  logic                              s_last_i,
  output logic                              m_valid_o,
  input  logic                              m_ready_i,
  output logic [7:0]                        m_data_o,
  output logic                              m_last_o,
  output logic                              mem_req_o,
  input  logic                              mem_ready_i,
  output logic                              mem_we_o,
  output logic [memreq_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  output logic [memreq_pkg::DATA_WIDTH-1:0] mem_wdata_o,
  input  logic                              mem_rvalid_i,
  input  logic [memreq_pkg::DATA_WIDTH-1:0] mem_rdata_i,
  input  logic                              mem_err_i
);
  import memreq_pkg::*;

  mem_cmd_t store_cmd;
  mem_cmd_t fetch_cmd;
  logic     store_cmd_valid;
  logic     store_cmd_ready;
  logic     fetch_cmd_valid;
  logic     fetch_cmd_ready;

  byte_stream_if host_in ();
  byte_stream_if host_out ();
  byte_stream_if payload ();
  byte_stream_if store_reply ();
  byte_stream_if fetch_reply ();
  mem_port_if    store_mem ();
  mem_port_if    fetch_mem ();
  mem_port_if    mem_bus ();  // Shared port after the arbiter

  assign host_in.valid = s_valid_i;
  assign host_in.data  = s_data_i;
  assign host_in.last  = s_last_i;
  assign s_ready_o     = host_in.ready;

  assign m_valid_o      = host_out.valid;
  assign m_data_o       = host_out.data;
  assign m_last_o       = host_out.last;
  assign host_out.ready = m_ready_i;

  assign mem_req_o      = mem_bus.req;
  assign mem_we_o       = mem_bus.we;
  assign mem_addr_o     = mem_bus.addr;
  assign mem_wdata_o    = mem_bus.wdata;
  assign mem_bus.ready  = mem_ready_i;
  assign mem_bus.rvalid = mem_rvalid_i;
  assign mem_bus.rdata  = mem_rdata_i;
  assign mem_bus.err    = mem_err_i;

  cmd_parser u_parser (
    .bus_clock         (bus_clock),
    .bus_reset         (bus_reset),
    .host              (host_in),
    .store_cmd_o       (store_cmd),
    .store_cmd_valid_o (store_cmd_valid),
    .store_cmd_ready_i (store_cmd_ready),
    .fetch_cmd_o       (fetch_cmd),
    .fetch_cmd_valid_o (fetch_cmd_valid),
    .fetch_cmd_ready_i (fetch_cmd_ready),
    .payload           (payload)
  );

  store_engine u_store (
    .bus_clock   (bus_clock),
    .bus_reset   (bus_reset),
    .cmd_i       (store_cmd),
    .cmd_valid_i (store_cmd_valid),
    .cmd_ready_o (store_cmd_ready),
    .payload     (payload),
    .mem         (store_mem),
    .reply       (store_reply)
  );

  fetch_engine u_fetch (
    .bus_clock   (bus_clock),
    .bus_reset   (bus_reset),
    .cmd_i       (fetch_cmd),
    .cmd_valid_i (fetch_cmd_valid),
    .cmd_ready_o (fetch_cmd_ready),
    .mem         (fetch_mem),
    .reply       (fetch_reply)
  );

  mem_arbiter u_arbiter (
    .bus_clock  (bus_clock),
    .bus_reset  (bus_reset),
    .store_port (store_mem),
    .fetch_port (fetch_mem),
    .mem        (mem_bus)
  );

  reply_mux u_reply_mux (
    .bus_clock   (bus_clock),
    .bus_reset   (bus_reset),
    .store_reply (store_reply),
    .fetch_reply (fetch_reply),
    .host        (host_out)
  );

endmodule

// File: tb_mem_model.sv
`timescale 1ns/10ps
module tb_mem_model (
  input  logic        bus_clock,
  input  logic        bus_reset,
  input  logic        mem_req_i,
  output logic        mem_ready_o,
  input  logic        mem_we_i,
  input  logic [23:0] mem_addr_i,
  input  logic [31:0] mem_wdata_i,
  output logic        mem_rvalid_o,
  output logic [31:0] mem_rdata_o,
  output logic        mem_err_o
);

  logic [31:0] lfsr_q = 32'hd666_395b;
  logic [31:0] cells [0:1023];   // Only low addresses are used by the tests
  logic [31:0] rsp_data [$];
  logic        rsp_err [$];
  int          rsp_wait [$];     // Extra cycles once at the head

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
    end
    return v;
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++) cells[i] = {8'ha5, 24'(i)};
    mem_ready_o  = 1'b0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    mem_err_o    = 1'b0;
    forever begin
      @(negedge bus_clock);
      mem_rvalid_o = 1'b0;
      mem_err_o    = 1'b0;
      if (rsp_wait.size() > 0) begin  // Responses leave in order
        if (rsp_wait[0] == 0) begin
          mem_rvalid_o = 1'b1;
          mem_rdata_o  = rsp_data.pop_front();
          mem_err_o    = rsp_err.pop_front();
          void'(rsp_wait.pop_front());
        end else begin
          rsp_wait[0] = rsp_wait[0] - 1;
        end
      end
      mem_ready_o = (rand_bits(2) != 2'd0) && !bus_reset;
      // Request and ready now hold until the rising edge that takes them
      if (mem_req_i && mem_ready_o) begin
        if (mem_addr_i[23]) begin
          rsp_data.push_back({8'he7, mem_addr_i});
          rsp_err.push_back(1'b1);
        end else begin
          if (mem_we_i) cells[mem_addr_i[9:0]] = mem_wdata_i;
          rsp_data.push_back(mem_we_i ? 32'h0 : cells[mem_addr_i[9:0]]);
          rsp_err.push_back(1'b0);
        end
        rsp_wait.push_back(int'(rand_bits(3)));
      end
    end
  end

endmodule

// File: memreq_tb.sv
`timescale 1ns/10ps
module memreq_tb;
  import memreq_pkg::*;

  typedef struct packed {
    logic [7:0]  kind;    // First byte of the frame
    logic [3:0]  tid;
    logic [23:0] addr;
    logic [4:0]  beats;   // Word count from 1 to 16
    logic [31:0] pat;     // XOR mask on the random payload words
    logic [7:0]  status;
    logic        reply;
    logic        chain;   // Sent without waiting for earlier replies
  } row_t;

  logic        bus_clock = 1'b0;
  logic        bus_reset;
  logic        s_valid, s_ready, s_last, m_valid, m_ready, m_last;
  logic [7:0]  s_data, m_data;
  logic        mem_req, mem_ready, mem_we, mem_rvalid, mem_err;
  logic [23:0] mem_addr;
  logic [31:0] mem_wdata, mem_rdata;

  logic [31:0] lfsr_q = 32'hd666_395b;
  row_t        rows [$];
  logic [31:0] words [0:31][0:15];    // Payload words of each row
  logic [31:0] shadow [0:1023];
  logic [7:0]  exp_frame [0:15][0:69];
  int          exp_len [0:15];
  logic        exp_open [0:15];
  string       exp_name [0:15];
  logic [7:0]  got_q [$];
  int          sent_cnt = 0;
  int          done_cnt = 0;
  int          cycles = 0;
  int          limit;

  memreq_top i_dut (
    .bus_clock (bus_clock), .bus_reset (bus_reset),
    .s_valid_i (s_valid), .s_ready_o (s_ready), .s_data_i (s_data), .s_last_i (s_last),
    .m_valid_o (m_valid), .m_ready_i (m_ready), .m_data_o (m_data), .m_last_o (m_last),
    .mem_req_o (mem_req), .mem_ready_i (mem_ready), .mem_we_o (mem_we),
    .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata), .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i (mem_rdata), .mem_err_i (mem_err)
  );

  tb_mem_model i_mem (
    .bus_clock (bus_clock), .bus_reset (bus_reset),
    .mem_req_i (mem_req), .mem_ready_o (mem_ready), .mem_we_i (mem_we),
    .mem_addr_i (mem_addr), .mem_wdata_i (mem_wdata), .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o (mem_rdata), .mem_err_o (mem_err)
  );

  initial begin
    forever #4 bus_clock = ~bus_clock;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
    end
    return v;
  endfunction

  // The model answers the bit 23 error region with a marker word
  function automatic logic [31:0] expected_word(input logic [23:0] a);
    expected_word = a[23] ? {8'he7, a} : shadow[a[9:0]];
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input int exp, input int act);
    stop_with_failure($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  task automatic add_row(input logic [7:0] kind, input logic [3:0] tid, input logic [23:0] addr,
                         input logic [4:0] beats, input logic [31:0] pat,
                         input logic [7:0] status, input logic reply, input logic chain);
    row_t r;
    r = '{kind, tid, addr, beats, pat, status, reply, chain};
    rows.push_back(r);
  endtask

  // Called on a falling edge and returns on the falling edge after the byte moved
  task automatic send_byte(input logic [7:0] b, input logic l);
    s_valid = 1'b1;
    s_data  = b;
    s_last  = l;
    while (!s_ready) @(negedge bus_clock);
    @(negedge bus_clock);
    s_valid = 1'b0;
  endtask

  task automatic apply_row(input int idx);
    row_t        r;
    logic [31:0] w;
    logic [23:0] a;
    logic [4:0]  bm;
    r  = rows[idx];
    bm = r.beats - 5'd1;
    if (r.reply) begin
      exp_open[r.tid]     = 1'b1;
      exp_name[r.tid]     = $sformatf("row%0d tid%0d", idx, r.tid);
      exp_frame[r.tid][0] = r.status;
      exp_frame[r.tid][1] = {4'h0, r.tid};  // Tid comes back in the low nibble
      exp_len[r.tid]      = (r.kind == CMD_FETCH) ? 2 + 4 * r.beats : 2;
      sent_cnt++;
    end
    if (r.kind == CMD_FETCH) begin
      for (int i = 0; i < r.beats; i++) begin
        w = expected_word(r.addr + 24'(i));
        for (int b = 0; b < 4; b++) exp_frame[r.tid][2 + 4 * i + b] = w[8 * b +: 8];
      end
    end
    send_byte(r.kind, 1'b0);
    send_byte({4'h0, bm[3:0]}, 1'b0);
    send_byte(r.addr[7:0], 1'b0);
    send_byte(r.addr[15:8], 1'b0);
    send_byte(r.addr[23:16], 1'b0);
    send_byte({r.tid, 4'h0}, r.kind == CMD_FETCH);
    if (r.kind != CMD_FETCH) begin   // Store payload or filler of an unknown frame
      for (int i = 0; i < r.beats; i++) begin
        w = words[idx][i];
        a = r.addr + 24'(i);
        if (r.kind == CMD_STORE && !a[23]) shadow[a[9:0]] = w;
        for (int b = 0; b < 4; b++) send_byte(w[8 * b +: 8], i == bm && b == 3);
      end
    end
  endtask

  task automatic check_frame;
    logic [3:0] t;
    t = (got_q.size() > 1) ? got_q[1][3:0] : 4'h0;
    assert (got_q.size() >= 2 && exp_open[t])
      else stop_with_failure($sformatf("reply of %0d bytes matches no open command", got_q.size()));
    assert (got_q.size() == exp_len[t])
      else report_mismatch({exp_name[t], " length"}, exp_len[t], got_q.size());
    for (int i = 0; i < exp_len[t]; i++) begin
      assert (got_q[i] == exp_frame[t][i])
        else report_mismatch($sformatf("%s byte %0d", exp_name[t], i), exp_frame[t][i], got_q[i]);
    end
    exp_open[t] = 1'b0;
    got_q.delete();
    done_cnt++;
  endtask

  // Reply side with random back-pressure
  initial begin
    forever begin
      @(negedge bus_clock);
      m_ready = (rand_bits(2) != 2'd0) && !bus_reset;
      if (m_valid && m_ready) begin
        got_q.push_back(m_data);
        if (m_last) check_frame();
      end
    end
  end

  always @(posedge bus_clock) begin
    cycles = cycles + 1;
    if (cycles > limit) stop_with_failure($sformatf("timeout, no finish within %0d cycles", limit));
  end

  initial begin
    bus_reset = 1'b1;
    s_valid   = 1'b0;
    s_data    = 8'h00;
    s_last    = 1'b0;
    m_ready   = 1'b0;
    for (int i = 0; i < 16; i++) exp_open[i] = 1'b0;
    for (int i = 0; i < 1024; i++) shadow[i] = {8'ha5, 24'(i)};
    add_row(CMD_STORE, 4'd1, 24'h000000, 5'd1, 32'h0, REPLY_WDONE, 1'b1, 1'b0);
    add_row(CMD_FETCH, 4'd2, 24'h000000, 5'd1, 32'h0, REPLY_RDATA, 1'b1, 1'b0);
    add_row(CMD_STORE, 4'd3, 24'h000010, 5'd4, 32'h1234_5678, REPLY_WDONE, 1'b1, 1'b0);
    add_row(CMD_FETCH, 4'd4, 24'h000010, 5'd4, 32'h0, REPLY_RDATA, 1'b1, 1'b0);
    add_row(CMD_STORE, 4'd5, 24'h000100, 5'd16, 32'h0, REPLY_WDONE, 1'b1, 1'b0);
    add_row(CMD_FETCH, 4'd6, 24'h000100, 5'd16, 32'h0, REPLY_RDATA, 1'b1, 1'b0);
    add_row(CMD_STORE, 4'd7, 24'h800020, 5'd2, 32'h0, REPLY_WFAIL, 1'b1, 1'b0);
    add_row(CMD_FETCH, 4'd8, 24'h800040, 5'd3, 32'h0, REPLY_RFAIL, 1'b1, 1'b0);
    add_row(8'h55,     4'd9, 24'h000010, 5'd2, 32'h0, 8'h00, 1'b0, 1'b0);  // Unknown command
    add_row(CMD_FETCH, 4'd10, 24'h000010, 5'd4, 32'h0, REPLY_RDATA, 1'b1, 1'b0);
    add_row(CMD_STORE, 4'd11, 24'h000200, 5'd8, 32'hffff_0000, REPLY_WDONE, 1'b1, 1'b0);
    add_row(CMD_FETCH, 4'd12, 24'h000100, 5'd16, 32'h0, REPLY_RDATA, 1'b1, 1'b1);
    add_row(CMD_FETCH, 4'd13, 24'h000200, 5'd8, 32'h0, REPLY_RDATA, 1'b1, 1'b0);
    limit = 200 * rows.size();
    for (int r = 0; r < rows.size(); r++) begin
      limit = limit + 64 * rows[r].beats;
      for (int i = 0; i < 16; i++) words[r][i] = rand_bits(32) ^ rows[r].pat;
    end
    repeat (4) @(posedge bus_clock);
    @(negedge bus_clock);
    bus_reset = 1'b0;
    assert (!m_valid && !mem_req)
      else stop_with_failure("m_valid_o or mem_req_o is high right after reset");
    for (int r = 0; r < rows.size(); r++) begin
      if (!rows[r].chain) begin
        while (done_cnt != sent_cnt) @(negedge bus_clock);
      end
      apply_row(r);
    end
    while (done_cnt != sent_cnt) @(negedge bus_clock);
    repeat (40) @(negedge bus_clock);  // Room for a stray reply to show up
    assert (got_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_failure("reply bytes arrived after the last expected frame");
    end
  end

endmodule

// File: vlog.f
memreq_pkg.sv
byte_stream_if.sv
mem_port_if.sv
cmd_parser.sv
store_engine.sv
fetch_engine.sv
mem_arbiter.sv
reply_mux.sv
memreq_top.sv
tb_mem_model.sv
memreq_tb.sv

// File: Bender.yml
package:
  name: memreq

sources:
  - memreq_pkg.sv
  - byte_stream_if.sv
  - mem_port_if.sv
  - cmd_parser.sv
  - store_engine.sv
  - fetch_engine.sv
  - mem_arbiter.sv
  - reply_mux.sv
  - memreq_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - memreq_tb.sv
